/* frame_ctrl.f */
+incdir+common
common/frame_ctrl_pkg.sv
verilog/ctrl_regs.sv
verilog/frame_seq.sv
load/fm_packer.sv
load/fm_loader.sv
save/fm_saver.sv
verilog/frame_ctrl_top.sv
verification/tb_frame_ctrl.sv

/* Makefile */
# Verilator flow for the frame controller
VERILATOR  ?= verilator
FILELIST   ?= frame_ctrl.f
TB_TOP     ?= tb_frame_ctrl
LINT_TOP   ?= frame_ctrl_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
SIM_FLAGS  ?= -Wno-fatal
PASS_TEXT  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_frame_ctrl.sv */
// ------------------------------
// frame controller testbench
// random stimulus from an LCG, fixed seed
// core is modelled as a delay only
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module tb_frame_ctrl;

    localparam int LB = `FC_LOAD_BYTES;
    localparam int LC = `FC_LOAD_COLS;
    localparam int PC = `FC_PE_COLS;
    localparam int WB = `FC_WORD_BYTES;
    localparam int WPT = `FC_SAVE_WORDS_PER_TURN;
    localparam int AW = `FC_BUF_AW;
    localparam int SAVE_BYTES = PC * WPT * WB * `FC_SAVE_ROUNDS;
    localparam int RUNS = 3;
    localparam int RUN_CYCLES = LB * 4 + SAVE_BYTES * 4 + 200;
    localparam int PCW = $clog2(PC);
    localparam int LBW = $clog2(LB);
    localparam int EV_CORE = 0;
    localparam int EV_IRQ = 1;
    localparam frame_ctrl_pkg::addr_t STRIDE = `FC_FRAME_STRIDE;

    logic clk = 1'b0;
    logic rst_n, start, mm2s_cmd_ready, s_tvalid, s_tlast;
    logic s2mm_cmd_ready, m_tready, core_finish;
    frame_ctrl_pkg::frm_idx_t frm_index;
    frame_ctrl_pkg::addr_t dma_addr;
    frame_ctrl_pkg::byte_t s_tdata, m_tdata;
    frame_ctrl_pkg::dm_cmd_t mm2s_cmd, s2mm_cmd;
    logic mm2s_cmd_valid, s_tready, s2mm_cmd_valid, m_tvalid, m_tkeep, m_tlast;
    logic core_valid, irq;
    frame_ctrl_pkg::fm_wr_t [LC-1:0] fm_wr;
    frame_ctrl_pkg::buf_addr_t [PC-1:0] fm_rd_addr;
    frame_ctrl_pkg::fm_word_t [PC-1:0] fm_dout = '0;

    // models and scoreboard state
    frame_ctrl_pkg::fm_word_t buf_mem [0:PC-1][0:(1<<AW)-1];
    frame_ctrl_pkg::byte_t in_bytes [0:LB-1];
    frame_ctrl_pkg::addr_t exp_load_addr, exp_save_addr;
    logic [31:0] rand_state = 32'd75989;
    int value_errs = 0;
    int other_errs = 0;
    int mm2s_cnt = 0;
    int s2mm_cnt = 0;
    int core_cnt = 0;
    int irq_cnt = 0;
    int out_cnt = 0;
    int wr_cnt [0:LC-1];
    logic finish_seen = 1'b0;
    logic last_seen = 1'b0;
    logic mm2s_wait = 1'b0;
    logic s2mm_wait = 1'b0;
    logic m_stall = 1'b0; // output byte offered and not taken
    frame_ctrl_pkg::byte_t stall_data = '0;
    logic stall_last = 1'b0;

    always #4 clk = ~clk;

    frame_ctrl_top i_frame_ctrl_top (.*);

    // registered read, one cycle after the address
    always @(posedge clk) begin
        for (int c = 0; c < PC; c++) fm_dout[c] <= buf_mem[c][fm_rd_addr[c]];
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {rand_state[15:0], rand_state[31:16]}; // upper bits are the better ones
    endfunction

    function automatic logic chance(input int pct);
        return (next_rand() % 32'd100) < 32'(pct);
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    task automatic check_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
        if (expected !== actual) begin
            value_errs++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        other_errs++;
        $display("ERROR: %s", msg);
    endtask

    function automatic frame_ctrl_pkg::dm_cmd_t make_cmd(input frame_ctrl_pkg::addr_t addr,
                                                         input int len);
        frame_ctrl_pkg::dm_cmd_t cmd;
        cmd = '0;
        cmd.saddr = addr;
        cmd.btt = `FC_BTT_W'(len);
        return cmd;
    endfunction

    // column gets every LC-th byte, 9 per word
    function automatic int words_in_col(input int col);
        int n;
        n = (LB - col + LC - 1) / LC;
        return (n + WB - 1) / WB;
    endfunction

    function automatic frame_ctrl_pkg::fm_word_t expected_load_word(input int col, input int w);
        frame_ctrl_pkg::fm_word_t word;
        int k;
        word = '0;
        for (int i = 0; i < WB; i++) begin
            k = col + LC * (WB * w + i);
            if (k < LB) word[8*(WB-1-i) +: 8] = in_bytes[LBW'(k)]; // zero fill past the end
        end
        return word;
    endfunction

    // rounds, then columns, then words of a turn
    function automatic frame_ctrl_pkg::byte_t expected_save_byte(input int idx);
        int w;
        int b;
        int rem;
        int c;
        int a;
        frame_ctrl_pkg::fm_word_t word;
        w = idx / WB;
        b = idx % WB;
        rem = w % (PC * WPT);
        c = rem / WPT;
        a = (w / (PC * WPT)) * WPT + rem % WPT;
        word = buf_mem[PCW'(c)][AW'(a)];
        return word[8*(WB-1-b) +: 8];
    endfunction

    function automatic int event_count(input int id);
        if (id == EV_CORE) return core_cnt;
        else return irq_cnt;
    endfunction

    task automatic tick();
        @(posedge clk);
        mm2s_cmd_ready <= chance(35);
        s2mm_cmd_ready <= chance(35);
        m_tready       <= chance(70);
    endtask

    task automatic wait_event(input int id, input int target, input int limit, input string what);
        int n;
        n = 0;
        while (event_count(id) < target && n < limit) begin
            tick();
            n++;
        end
        if (event_count(id) < target) note_failure($sformatf("no %s pulse seen", what));
    endtask

    task automatic stream_frame();
        int gap;
        for (int k = 0; k < LB; k++) begin
            gap = rand_below(3);
            repeat (gap) begin
                s_tvalid <= 1'b0;
                tick();
            end
            s_tvalid <= 1'b1;
            s_tdata  <= in_bytes[LBW'(k)];
            s_tlast  <= (k == LB - 1);
            do begin
                tick();
            end while (!s_tready); // beat taken at this edge
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
    endtask

    task automatic run_one(input int run);
        frame_ctrl_pkg::frm_idx_t idx;
        frame_ctrl_pkg::addr_t base;
        idx = 8'(next_rand());
        base = next_rand();
        exp_load_addr = base + STRIDE * {24'h0, idx};
        exp_save_addr = base + STRIDE * 32'(`FC_SAVE_SLOT);
        for (int c = 0; c < PC; c++) begin
            for (int a = 0; a < (1 << AW); a++) begin
                buf_mem[c][a] = {next_rand(), next_rand(), 8'(next_rand())};
            end
        end
        for (int k = 0; k < LB; k++) in_bytes[k] = 8'(next_rand());
        tick();
        start     <= 1'b1;
        frm_index <= idx;
        dma_addr  <= base;
        tick();
        start <= 1'b0;
        tick();
        frm_index <= 8'(next_rand()); // software moves on mid-run
        dma_addr  <= next_rand();
        stream_frame();
        wait_event(EV_CORE, run + 1, 50, "core_valid");
        start <= 1'b1; // busy, must be dropped
        tick();
        start <= 1'b0;
        repeat (rand_below(20)) tick();
        core_finish <= 1'b1;
        tick();
        core_finish <= 1'b0;
        repeat (5) tick();
        start <= 1'b1;
        tick();
        start <= 1'b0;
        wait_event(EV_IRQ, run + 1, SAVE_BYTES * 4, "irq");
        repeat (20) tick();
        check_value("load commands", 72'(run + 1), 72'(mm2s_cnt));
        check_value("save commands", 72'(run + 1), 72'(s2mm_cnt));
        check_value("core_valid pulses", 72'(run + 1), 72'(core_cnt));
        check_value("irq pulses", 72'(run + 1), 72'(irq_cnt));
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (mm2s_wait && !mm2s_cmd_valid) note_failure("mm2s command dropped before ready");
            if (s2mm_wait && !s2mm_cmd_valid) note_failure("s2mm command dropped before ready");
            mm2s_wait = mm2s_cmd_valid && !mm2s_cmd_ready;
            s2mm_wait = s2mm_cmd_valid && !s2mm_cmd_ready;
            if (mm2s_cmd_valid && mm2s_cmd_ready) begin
                check_value("mm2s command", 72'(make_cmd(exp_load_addr, LB)), 72'(mm2s_cmd));
                mm2s_cnt++;
                out_cnt = 0; // new run
                for (int j = 0; j < LC; j++) wr_cnt[j] = 0;
            end
            if (s2mm_cmd_valid && !finish_seen) note_failure("save command before core_finish");
            if (s2mm_cmd_valid && s2mm_cmd_ready) begin
                check_value("s2mm command", 72'(make_cmd(exp_save_addr, SAVE_BYTES)),
                            72'(s2mm_cmd));
                s2mm_cnt++;
            end
            if (core_finish) finish_seen = 1'b1;
            if (s_tvalid && s_tready && s_tlast) last_seen = 1'b1;
            if (core_valid) begin
                core_cnt++;
                if (!last_seen) note_failure("core_valid before the last input beat");
            end
            for (int j = 0; j < LC; j++) begin
                if (fm_wr[j].en) begin
                    if (wr_cnt[j] >= words_in_col(j)) begin
                        note_failure($sformatf("extra write to load column %0d", j));
                    end else begin
                        check_value($sformatf("column %0d write address", j),
                                    72'(wr_cnt[j]), 72'(fm_wr[j].addr));
                        check_value($sformatf("column %0d word %0d", j, wr_cnt[j]),
                                    expected_load_word(j, wr_cnt[j]), fm_wr[j].data);
                    end
                    wr_cnt[j]++;
                end
            end
            // a stalled byte must stay offered and unchanged
            if (m_stall) begin
                if (!m_tvalid) begin
                    note_failure("m_tvalid dropped before m_tready");
                end else begin
                    check_value("stalled m_tdata", 72'(stall_data), 72'(m_tdata));
                    check_value("stalled m_tlast", 72'(stall_last), 72'(m_tlast));
                end
            end
            m_stall    = m_tvalid && !m_tready;
            stall_data = m_tdata;
            stall_last = m_tlast;
            if (m_tvalid) check_value("m_tkeep", 72'(1), 72'(m_tkeep));
            if (m_tvalid && m_tready) begin
                if (out_cnt >= SAVE_BYTES) begin
                    note_failure("output byte past the end of the save");
                end else begin
                    check_value($sformatf("save byte %0d", out_cnt),
                                72'(expected_save_byte(out_cnt)), 72'(m_tdata));
                    check_value("m_tlast", 72'(out_cnt == SAVE_BYTES - 1), 72'(m_tlast));
                end
                out_cnt++;
            end
            if (irq) begin
                irq_cnt++;
                if (out_cnt != SAVE_BYTES) note_failure("irq before the last output byte");
                for (int j = 0; j < LC; j++) begin
                    check_value($sformatf("column %0d word count", j),
                                72'(words_in_col(j)), 72'(wr_cnt[j]));
                end
                finish_seen = 1'b0;
                last_seen   = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (RUNS * RUN_CYCLES) @(posedge clk);
        $display("ERROR: timeout, run did not complete in %0d cycles", RUNS * RUN_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        rst_n          = 1'b0;
        start          = 1'b0;
        frm_index      = '0;
        dma_addr       = '0;
        mm2s_cmd_ready = 1'b0;
        s_tvalid       = 1'b0;
        s_tdata        = '0;
        s_tlast        = 1'b0;
        s2mm_cmd_ready = 1'b0;
        m_tready       = 1'b0;
        core_finish    = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        tick();
        check_value("outputs after reset", 72'(0),
                    72'({mm2s_cmd_valid, s2mm_cmd_valid, s_tready, m_tvalid, m_tlast,
                         core_valid, irq}));
        for (int j = 0; j < LC; j++) check_value("write enable after reset", 72'(0),
                                                 72'(fm_wr[j].en));
        for (int run = 0; run < RUNS; run++) run_one(run);
        $display("checks done: %0d value mismatches, %0d other failures",
                 value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/frame_ctrl_top.sv */
// ------------------------------
// frame controller top
// buffer read data is one cycle late
// one frame per start, busy starts dropped
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module frame_ctrl_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              start,
    input  frame_ctrl_pkg::frm_idx_t                          frm_index,
    input  frame_ctrl_pkg::addr_t                             dma_addr,
    output logic                                              mm2s_cmd_valid,
    input  logic                                              mm2s_cmd_ready,
    output frame_ctrl_pkg::dm_cmd_t                           mm2s_cmd,
    input  logic                                              s_tvalid,
    output logic                                              s_tready,
    input  frame_ctrl_pkg::byte_t                             s_tdata,
    input  logic                                              s_tlast,
    output logic                                              s2mm_cmd_valid,
    input  logic                                              s2mm_cmd_ready,
    output frame_ctrl_pkg::dm_cmd_t                           s2mm_cmd,
    output logic                                              m_tvalid,
    input  logic                                              m_tready,
    output frame_ctrl_pkg::byte_t                             m_tdata,
    output logic                                              m_tkeep,
    output logic                                              m_tlast,
    output logic                                              core_valid,
    input  logic                                              core_finish,
    output frame_ctrl_pkg::fm_wr_t    [`FC_LOAD_COLS-1:0]     fm_wr,
    output frame_ctrl_pkg::buf_addr_t [`FC_PE_COLS-1:0]       fm_rd_addr,
    input  frame_ctrl_pkg::fm_word_t  [`FC_PE_COLS-1:0]       fm_dout,
    output logic                                              irq
);

    logic run_start;
    logic load_go, load_done;
    logic save_go, save_done;
    frame_ctrl_pkg::addr_t load_addr, save_addr;

    ctrl_regs i_ctrl_regs (
        .clk, .rst_n, .run_start, .frm_index, .dma_addr,
        .load_addr, .save_addr
    );

    frame_seq i_frame_seq (
        .clk, .rst_n, .start, .load_done, .core_finish, .save_done,
        .run_start, .load_go, .save_go, .core_valid, .irq
    );

    fm_loader i_fm_loader (
        .clk, .rst_n, .load_go, .load_addr, .mm2s_cmd_ready,
        .s_tvalid, .s_tdata, .s_tlast,
        .mm2s_cmd_valid, .mm2s_cmd, .s_tready, .fm_wr, .load_done
    );

    fm_saver i_fm_saver (
        .clk, .rst_n, .save_go, .save_addr, .s2mm_cmd_ready, .m_tready, .fm_dout,
        .s2mm_cmd_valid, .s2mm_cmd, .m_tvalid, .m_tdata, .m_tkeep, .m_tlast,
        .fm_rd_addr, .save_done
    );

endmodule

/* save/fm_saver.sv */
// ------------------------------
// result saver
// buffer dout must follow fm_rd_addr by one cycle
// one read bubble per word, msb byte first
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module fm_saver (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          save_go,
    input  frame_ctrl_pkg::addr_t                         save_addr,
    input  logic                                          s2mm_cmd_ready,
    input  logic                                          m_tready,
    input  frame_ctrl_pkg::fm_word_t  [`FC_PE_COLS-1:0]   fm_dout,
    output logic                                          s2mm_cmd_valid,
    output frame_ctrl_pkg::dm_cmd_t                       s2mm_cmd,
    output logic                                          m_tvalid,
    output frame_ctrl_pkg::byte_t                         m_tdata,
    output logic                                          m_tkeep,
    output logic                                          m_tlast,
    output frame_ctrl_pkg::buf_addr_t [`FC_PE_COLS-1:0]   fm_rd_addr,
    output logic                                          save_done
);

    localparam int COLS = `FC_PE_COLS;
    localparam int WPT = `FC_SAVE_WORDS_PER_TURN;
    localparam int ROUNDS = `FC_SAVE_ROUNDS;
    localparam int WB = `FC_WORD_BYTES;
    localparam int BTT_W = `FC_BTT_W;
    localparam int SAVE_BYTES = COLS * WPT * WB * ROUNDS;
    localparam int CLW = (COLS > 1) ? $clog2(COLS) : 1;
    localparam int TW = (WPT > 1) ? $clog2(WPT) : 1;
    localparam int RW = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
    localparam int BW = $clog2(WB + 1);

    frame_ctrl_pkg::eng_state_e state;
    frame_ctrl_pkg::fm_word_t shift;
    logic [CLW-1:0] col;
    logic [TW-1:0] turn_cnt;
    logic [RW-1:0] round_cnt;
    logic [BW-1:0] bytes_left;
    logic last_word;
    logic fetch, hs, turn_end, col_end, final_word;

    assign s2mm_cmd_valid = (state == frame_ctrl_pkg::CMD);
    assign s2mm_cmd = '{rsvd: 8'h00, saddr: save_addr, tag: 8'h00, dm_type: 1'b0,
                        btt: BTT_W'(SAVE_BYTES)};

    assign fetch      = (state == frame_ctrl_pkg::XFER) && (bytes_left == '0);
    assign turn_end   = (turn_cnt == TW'(WPT - 1));
    assign col_end    = (col == CLW'(COLS - 1));
    assign final_word = turn_end && col_end && (round_cnt == RW'(ROUNDS - 1));

    assign m_tvalid = (bytes_left != '0);
    assign m_tdata  = shift[8*WB-1 -: 8];
    assign m_tkeep  = 1'b1;
    assign m_tlast  = m_tvalid && last_word && (bytes_left == BW'(1));
    assign hs       = m_tvalid && m_tready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= frame_ctrl_pkg::STOP;
            col        <= '0;
            turn_cnt   <= '0;
            round_cnt  <= '0;
            bytes_left <= '0;
            last_word  <= 1'b0;
            fm_rd_addr <= '0;
            save_done  <= 1'b0;
        end else begin
            save_done <= 1'b0;
            case (state)
                frame_ctrl_pkg::STOP: begin
                    if (save_go) begin
                        state      <= frame_ctrl_pkg::CMD;
                        col        <= '0;
                        turn_cnt   <= '0;
                        round_cnt  <= '0;
                        last_word  <= 1'b0;
                        fm_rd_addr <= '0;
                    end
                end
                frame_ctrl_pkg::CMD: if (s2mm_cmd_ready) state <= frame_ctrl_pkg::XFER;
                frame_ctrl_pkg::XFER: begin
                    if (fetch) begin
                        bytes_left      <= BW'(WB);
                        last_word       <= final_word;
                        fm_rd_addr[col] <= fm_rd_addr[col] + 1'b1; // settles long before next use
                        turn_cnt        <= turn_end ? '0 : turn_cnt + 1'b1;
                        if (turn_end) begin
                            col <= col_end ? '0 : col + 1'b1;
                            if (col_end) round_cnt <= round_cnt + 1'b1;
                        end
                    end else if (hs) begin
                        bytes_left <= bytes_left - 1'b1;
                        if (m_tlast) begin
                            state     <= frame_ctrl_pkg::STOP;
                            save_done <= 1'b1;
                        end
                    end
                end
                default: state <= frame_ctrl_pkg::STOP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            shift <= fm_dout[col];
        end else if (hs) begin
            shift <= shift << 8;
        end
    end

    a_tdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

/* load/fm_loader.sv */
// ------------------------------
// frame loader
// bytes go round-robin over the load columns
// load_addr must be valid when the command is up
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module fm_loader (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           load_go,
    input  frame_ctrl_pkg::addr_t                          load_addr,
    input  logic                                           mm2s_cmd_ready,
    input  logic                                           s_tvalid,
    input  frame_ctrl_pkg::byte_t                          s_tdata,
    input  logic                                           s_tlast,
    output logic                                           mm2s_cmd_valid,
    output frame_ctrl_pkg::dm_cmd_t                        mm2s_cmd,
    output logic                                           s_tready,
    output frame_ctrl_pkg::fm_wr_t [`FC_LOAD_COLS-1:0]     fm_wr,
    output logic                                           load_done
);

    localparam int COLS = `FC_LOAD_COLS;
    localparam int BTT_W = `FC_BTT_W;

    frame_ctrl_pkg::eng_state_e state;
    logic [COLS-1:0] col_sel; // one-hot
    logic beat;

    assign mm2s_cmd_valid = (state == frame_ctrl_pkg::CMD);
    assign mm2s_cmd = '{rsvd: 8'h00, saddr: load_addr, tag: 8'h00, dm_type: 1'b0,
                        btt: BTT_W'(`FC_LOAD_BYTES)};

    assign s_tready  = (state == frame_ctrl_pkg::XFER);
    assign beat      = s_tvalid && s_tready;
    assign load_done = beat && s_tlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= frame_ctrl_pkg::STOP;
        end else begin
            case (state)
                frame_ctrl_pkg::STOP: if (load_go) state <= frame_ctrl_pkg::CMD;
                frame_ctrl_pkg::CMD:  if (mm2s_cmd_ready) state <= frame_ctrl_pkg::XFER;
                frame_ctrl_pkg::XFER: if (load_done) state <= frame_ctrl_pkg::STOP;
                default: state <= frame_ctrl_pkg::STOP;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_sel <= COLS'(1);
        end else if (load_go) begin
            col_sel <= COLS'(1);
        end else if (beat) begin
            col_sel <= {col_sel[COLS-2:0], col_sel[COLS-1]};
        end
    end

    for (genvar j = 0; j < COLS; j++) begin : g_col
        fm_packer i_fm_packer (
            .clk, .rst_n,
            .clear (load_go),
            .beat  (beat),
            .sel   (col_sel[j]),
            .last  (s_tlast),
            .data  (s_tdata),
            .wr    (fm_wr[j])
        );
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(col_sel));
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mm2s_cmd_valid && !mm2s_cmd_ready |=> mm2s_cmd_valid && $stable(mm2s_cmd));

endmodule

/* load/fm_packer.sv */
// ------------------------------
// one column byte packer
// first byte ends up in the top of the word
// write port is combinational
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module fm_packer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   beat,
    input  logic                   sel,
    input  logic                   last,
    input  frame_ctrl_pkg::byte_t  data,
    output frame_ctrl_pkg::fm_wr_t wr
);

    localparam int WB = `FC_WORD_BYTES;
    localparam int CW = $clog2(WB);
    localparam logic [CW-1:0] LAST_CNT = CW'(WB - 1);

    logic [8*(WB-1)-1:0] shift; // pending bytes, newest at the bottom
    logic [CW-1:0] cnt;
    frame_ctrl_pkg::buf_addr_t addr;
    frame_ctrl_pkg::fm_word_t full_word, flush_word;
    logic full;

    assign full      = sel && (cnt == LAST_CNT);
    assign full_word = {shift, data};

    always_comb begin
        // left align the partial word, zeros fill the tail
        if (sel) begin
            flush_word = full_word << (8 * (WB - 1 - int'(cnt)));
        end else begin
            flush_word = {8'h00, shift} << (8 * (WB - int'(cnt)));
        end
        wr.en   = beat && (full || (last && (sel || cnt != '0)));
        wr.addr = addr;
        wr.data = last ? flush_word : full_word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            addr <= '0;
        end else if (clear) begin
            cnt  <= '0;
            addr <= '0;
        end else begin
            if (beat && sel) cnt <= full ? '0 : cnt + 1'b1;
            if (wr.en) addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat && sel) shift <= {shift[8*(WB-2)-1:0], data};
    end

endmodule

/* verilog/frame_seq.sv */
// ------------------------------
// top sequencer
// all strobes are registered, one cycle wide
// start outside IDLE is dropped
// ------------------------------
`timescale 1ns/1ps

module frame_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic load_done,
    input  logic core_finish,
    input  logic save_done,
    output logic run_start,
    output logic load_go,
    output logic save_go,
    output logic core_valid,
    output logic irq
);

    frame_ctrl_pkg::seq_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= frame_ctrl_pkg::IDLE;
            run_start  <= 1'b0;
            load_go    <= 1'b0;
            save_go    <= 1'b0;
            core_valid <= 1'b0;
            irq        <= 1'b0;
        end else begin
            run_start  <= 1'b0;
            load_go    <= 1'b0;
            save_go    <= 1'b0;
            core_valid <= 1'b0;
            irq        <= 1'b0;
            case (state)
                frame_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state     <= frame_ctrl_pkg::LOAD;
                        run_start <= 1'b1;
                        load_go   <= 1'b1;
                    end
                end
                frame_ctrl_pkg::LOAD: begin
                    if (load_done) begin
                        state      <= frame_ctrl_pkg::CORE;
                        core_valid <= 1'b1; // frame is in the buffer
                    end
                end
                frame_ctrl_pkg::CORE: begin
                    if (core_finish) begin
                        state   <= frame_ctrl_pkg::SAVE;
                        save_go <= 1'b1;
                    end
                end
                frame_ctrl_pkg::SAVE: begin
                    if (save_done) begin
                        state <= frame_ctrl_pkg::FINISH;
                        irq   <= 1'b1;
                    end
                end
                default: state <= frame_ctrl_pkg::IDLE; // FINISH
            endcase
        end
    end

    // engines only report inside their own phase
    a_load_done_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_done |-> state == frame_ctrl_pkg::LOAD);
    a_save_done_in_save: assert property (@(posedge clk) disable iff (!rst_n)
        save_done |-> state == frame_ctrl_pkg::SAVE);

endmodule

/* verilog/ctrl_regs.sv */
// ------------------------------
// run configuration latch
// dma_addr and frm_index must hold
// through the run_start cycle
// ------------------------------
`timescale 1ns/1ps
`include "frame_ctrl_cfg.svh"

module ctrl_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run_start,
    input  frame_ctrl_pkg::frm_idx_t frm_index,
    input  frame_ctrl_pkg::addr_t    dma_addr,
    output frame_ctrl_pkg::addr_t    load_addr,
    output frame_ctrl_pkg::addr_t    save_addr
);

    localparam frame_ctrl_pkg::addr_t STRIDE = `FC_FRAME_STRIDE;
    localparam frame_ctrl_pkg::addr_t SAVE_OFS = STRIDE * `FC_SAVE_SLOT;

    frame_ctrl_pkg::addr_t frm_ofs;

    // frame offset inside the dma window
    assign frm_ofs = STRIDE * frame_ctrl_pkg::addr_t'(frm_index);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_addr <= '0;
            save_addr <= '0;
        end else if (run_start) begin
            load_addr <= dma_addr + frm_ofs;
            save_addr <= dma_addr + SAVE_OFS; // fixed result slot
        end
    end

endmodule

/* common/frame_ctrl_pkg.sv */
// ------------------------------
// types shared by the frame controller
// fm_word_t is 9 bytes wide
// ------------------------------
`include "frame_ctrl_cfg.svh"

package frame_ctrl_pkg;

    typedef logic [`FC_ADDR_W-1:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [8*`FC_WORD_BYTES-1:0] fm_word_t;
    typedef logic [`FC_BUF_AW-1:0] buf_addr_t;
    typedef logic [7:0] frm_idx_t;

    // 72-bit datamover command
    typedef struct packed {
        logic [7:0] rsvd;
        addr_t saddr;
        logic [7:0] tag;
        logic dm_type; // 0 = fixed, not used here
        logic [`FC_BTT_W-1:0] btt;
    } dm_cmd_t;

    typedef struct packed {
        logic en;
        buf_addr_t addr;
        fm_word_t data;
    } fm_wr_t;

    typedef enum logic [2:0] {IDLE, LOAD, CORE, SAVE, FINISH} seq_state_e;

    typedef enum logic [1:0] {STOP, CMD, XFER} eng_state_e;

endpackage

/* common/frame_ctrl_cfg.svh */
// ------------------------------
// build constants for the frame controller
// column counts must match the buffer instance
// FC_LOAD_BYTES must fit in FC_BTT_W bits
// ------------------------------
`ifndef FRAME_CTRL_CFG_SVH
`define FRAME_CTRL_CFG_SVH

// buffer geometry
`define FC_LOAD_COLS 3
`define FC_PE_COLS 4
`define FC_WORD_BYTES 9
`define FC_BUF_AW 8

// datamover command fields
`define FC_ADDR_W 32
`define FC_BTT_W 23

// memory layout, frames are one stride apart
`define FC_FRAME_STRIDE 32'h0006_0000
`define FC_SAVE_SLOT 17

`define FC_LOAD_BYTES 100 // not a multiple of 27, last word is partial

// save order
`define FC_SAVE_WORDS_PER_TURN 2
`define FC_SAVE_ROUNDS 4

`endif
